// ==== project.f ====
+incdir+include
source/reveal_pkg.sv
source/host_regs.sv
source/pattern_store.sv
source/pattern_fifo.sv
source/pattern_loader.sv
source/exposure_fsm.sv
source/reveal_top.sv
testbench/tb_reveal.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f) include/reveal_defs.svh

obj_dir/Vtb_reveal: project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module tb_reveal -o Vtb_reveal

run: obj_dir/Vtb_reveal
	./obj_dir/Vtb_reveal > sim.log; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== testbench/tb_reveal.sv ====
`include "reveal_defs.svh"

module tb_reveal import reveal_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] status_idle = 32'(IDLE) << 6;   // state field sits above subframe

	logic         CLK_HS;
	logic         arst_n;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	logic         expose_req;
	logic         expose_ack;
	imager_ctrl_t imager;
	logic         trigger_proj;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int err_mark = 0;
	int cycles = 0;
	int limit = 0;
	int exp_a;     // chosen frame config
	int num_a;
	int min_a;
	int delay_a;

	// reference state rebuilt from bus traffic and the frame rules
	pattern_t                  store_m [`REVEAL_MAX_PAT];
	logic                      sr_m;        // soft reset as the host set it
	int                        exp_m;
	int                        num_m;
	int                        min_m;
	int                        delay_m;
	int                        str_cnt;     // stream pulses in this frame
	logic [`REVEAL_PAT_AW-1:0] str_idx;
	int                        since_str;   // cycles since the last stream pulse
	int                        trig_sub;    // triggers in the current subframe
	int                        frame_cyc;   // cycles since expose_req was sampled high
	int                        trig_exp;
	logic                      ack_d;
	logic                      req_d;
	logic                      drain_d;
	logic                      ack_rise;

	reveal_top dut_i (.CLK_HS, .arst_n, .apb_req, .apb_rsp, .expose_req, .expose_ack,
		.imager, .trigger_proj);

	initial begin
		CLK_HS = 1'b0;
		forever #5 CLK_HS = ~CLK_HS;   // 100 MHz
	end

	// run limit worked out once the config is chosen
	always @(posedge CLK_HS) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic void report_error(input string msg);
		errors++;
		$display("%s", msg);
	endfunction

	function automatic int frame_len(input int n);
		return n * (exp_a + 1 + `REVEAL_FIFO_DEPTH) + min_a;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference tracking
	////////////////////////////////////////////////////////////////////////////
	assign trig_exp = (delay_m < exp_m) ? 1 : 0;   // one trigger per subframe if it fits
	assign ack_rise = expose_ack && !ack_d;

	always @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			sr_m      <= 1'b1;
			exp_m     <= 1;   // config comes up as 1
			num_m     <= 1;
			min_m     <= 1;
			delay_m   <= 1;
			str_cnt   <= 0;
			str_idx   <= '0;
			since_str <= 0;
			trig_sub  <= 0;
			frame_cyc <= 0;
			ack_d     <= 1'b0;
			req_d     <= 1'b0;
			drain_d   <= 1'b1;
		end else begin
			if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
				case (apb_req.paddr)
					`REVEAL_REG_CTRL:       sr_m <= apb_req.pwdata[0];
					`REVEAL_REG_EXP:        exp_m <= int'(apb_req.pwdata[15:0]);
					`REVEAL_REG_MIN_FRAME:  min_m <= int'(apb_req.pwdata[19:0]);
					`REVEAL_REG_PROJ_DELAY: delay_m <= int'(apb_req.pwdata[15:0]);
					`REVEAL_REG_NUM_PAT: begin
						if (apb_req.pwdata <= `REVEAL_MAX_PAT)   // larger counts are refused
							num_m <= int'(apb_req.pwdata);
					end
					default: ;
				endcase
			end
			if (!expose_req) begin
				str_cnt   <= 0;   // new frame starts from pattern 0
				str_idx   <= '0;
				frame_cyc <= 0;
			end else begin
				frame_cyc <= frame_cyc + 1;
				if (imager.stream) begin
					str_cnt <= str_cnt + 1;
					str_idx <= str_idx + 1'b1;
				end
			end
			if (imager.stream) begin
				since_str <= 1;
				trig_sub  <= 0;
			end else begin
				since_str <= since_str + 1;
				if (trigger_proj) trig_sub <= trig_sub + 1;
			end
			ack_d   <= expose_ack;
			req_d   <= expose_req;
			drain_d <= imager.drain_b;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	chk_idle: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		sr_m |-> !imager.stream && !imager.pix_res_glob && imager.drain_b
			&& !trigger_proj && !expose_ack)
		else report_error("imager controls or expose_ack active while soft reset is set");
	chk_count: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		imager.stream |-> str_cnt < num_m)
		else report_error("more stream pulses than num_pat in one frame");
	chk_mask: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		imager.stream |-> imager.mask == store_m[str_idx])
		else begin
			errors++;
			$display("[FAIL] imager.mask pulse %0d exp %h got %h", str_cnt, store_m[str_idx],
				imager.mask);
		end
	chk_gap: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		imager.stream && str_cnt != 0 |-> since_str >= exp_m + 1)
		else begin
			errors++;
			$display("[FAIL] stream spacing exp >= %h got %h", exp_m + 1, since_str);
		end
	chk_trig_fit: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		trigger_proj |-> delay_m < exp_m)
		else report_error("trigger_proj pulsed although proj_delay is not below exp_time");
	chk_trig_pos: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		trigger_proj |-> since_str == delay_m + 1)
		else begin
			errors++;
			$display("[FAIL] trigger_proj offset exp %h got %h", delay_m + 1, since_str);
		end
	chk_trig_once: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		trigger_proj |-> trig_sub == 0)
		else report_error("second trigger_proj pulse inside one subframe");
	chk_trig_seen: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		(imager.stream && str_cnt != 0) || (ack_rise && num_m != 0) |-> trig_sub == trig_exp)
		else begin
			errors++;
			$display("[FAIL] trigger_proj pulses per subframe exp %h got %h", trig_exp, trig_sub);
		end
	chk_ack_all: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		ack_rise |-> str_cnt == num_m)
		else begin
			errors++;
			$display("[FAIL] stream pulses at expose_ack exp %h got %h", num_m, str_cnt);
		end
	chk_ack_time: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		ack_rise |-> frame_cyc >= min_m)
		else begin
			errors++;
			$display("[FAIL] frame length at expose_ack exp >= %h got %h", min_m, frame_cyc);
		end
	chk_ack_drain: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		ack_rise |-> !drain_d)
		else report_error("drain_b was not low on the cycle before expose_ack rose");
	chk_ack_hold: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		ack_d && req_d && !sr_m |-> expose_ack)
		else report_error("expose_ack dropped while expose_req was still high");
	chk_ack_fall: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		ack_d && !req_d |-> !expose_ack)
		else report_error("expose_ack still high a cycle after expose_req was sampled low");

	////////////////////////////////////////////////////////////////////////////
	// bus and frame tasks driving inputs on the falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		input logic [31:0] exp_rd, input logic [31:0] rd_mask, input logic exp_err);
		@(negedge CLK_HS);
		apb_req.psel    = 1'b1;   // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge CLK_HS);
		apb_req.penable = 1'b1;
		#2;   // mid access phase where the response has settled
		assert (apb_rsp.pready) else report_error("pready low in the access phase");
		assert (apb_rsp.pslverr == exp_err)
			else begin
				errors++;
				$display("[FAIL] pslverr at %h exp %h got %h", addr, exp_err, apb_rsp.pslverr);
			end
		assert (wr || (apb_rsp.prdata & rd_mask) == (exp_rd & rd_mask))
			else begin
				errors++;
				$display("[FAIL] prdata at %h exp %h got %h", addr, exp_rd & rd_mask,
					apb_rsp.prdata & rd_mask);
			end
		@(negedge CLK_HS);
		apb_req = '0;
	endtask

	task automatic run_frame(input int bound);
		int n;
		@(negedge CLK_HS);
		expose_req = 1'b1;
		n = 0;
		while (!expose_ack && n < bound) begin
			@(negedge CLK_HS);
			n++;
		end
		assert (expose_ack) else report_error("no expose_ack within the frame bound");
		repeat (1 + $urandom % 3) @(negedge CLK_HS);   // host holds the request a little
		expose_req = 1'b0;
		n = 0;
		while (expose_ack && n < 8) begin
			@(negedge CLK_HS);
			n++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors != err_mark) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, errors - err_mark);
		end else begin
			$display("test %0d %s: ok", num, name);
		end
		err_mark = errors;
	endtask

	initial begin
		logic [`REVEAL_PAT_AW-1:0] wa;
		pattern_t                  pat;
		int                        n;
		void'($urandom(32'h47ec));
		apb_req    = '0;
		expose_req = 1'b0;
		arst_n     = 1'b0;
		exp_a      = 3 + $urandom % 16;
		num_a      = 3 + $urandom % 8;
		min_a      = 40 + $urandom % 400;
		delay_a    = $urandom % exp_a;   // fits inside the subframe
		limit      = 6 * 200 + 4 * frame_len(num_a) + frame_len(0);

		repeat (16) @(posedge CLK_HS);
		@(negedge CLK_HS);
		arst_n = 1'b1;
		@(negedge CLK_HS);
		assert (!imager.stream && !imager.pix_res_glob && !trigger_proj && !expose_ack
			&& imager.drain_b) else report_error("outputs not idle after reset");
		apb_xfer(1'b0, `REVEAL_REG_CTRL, 0, 32'h1, 32'h1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_EXP, 0, 32'h1, '1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_NUM_PAT, 0, 32'h1, '1, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_CTRL, 0, 0, 0, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_STATUS, 0, status_idle, 32'h1c0, 1'b0);
		end_test(1, "reset state");

		apb_xfer(1'b1, `REVEAL_REG_EXP, exp_a, 0, 0, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_NUM_PAT, num_a, 0, 0, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_MIN_FRAME, min_a, 0, 0, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_PROJ_DELAY, delay_a, 0, 0, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_EXP, 0, exp_a, '1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_NUM_PAT, 0, num_a, '1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_MIN_FRAME, 0, min_a, '1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_PROJ_DELAY, 0, delay_a, '1, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_PAT_DATA, 0, 0, '1, 1'b0);
		apb_xfer(1'b0, 8'h20, 0, 0, 0, 1'b1);             // unmapped read
		apb_xfer(1'b1, 8'h24, 32'h5a, 0, 0, 1'b1);        // unmapped write
		apb_xfer(1'b1, `REVEAL_REG_STATUS, 32'h1ff, 0, 0, 1'b1);
		apb_xfer(1'b0, `REVEAL_REG_STATUS, 0, status_idle, 32'h1ff, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_NUM_PAT, 33 + $urandom % 20, 0, 0, 1'b1);
		apb_xfer(1'b0, `REVEAL_REG_NUM_PAT, 0, num_a, '1, 1'b0);
		end_test(2, "register access");

		// fill the whole store so the pointer wraps back to 0
		apb_xfer(1'b1, `REVEAL_REG_PAT_ADDR, 0, 0, 0, 1'b0);
		wa = '0;
		repeat (`REVEAL_MAX_PAT) begin
			pat         = pattern_t'($urandom);
			store_m[wa] = pat;
			apb_xfer(1'b1, `REVEAL_REG_PAT_DATA, {14'b0, pat}, 0, 0, 1'b0);
			wa++;
		end
		apb_xfer(1'b0, `REVEAL_REG_PAT_ADDR, 0, 0, '1, 1'b0);
		run_frame(frame_len(num_a) + 200);
		end_test(3, "pattern frame");

		apb_xfer(1'b1, `REVEAL_REG_PROJ_DELAY, exp_a + $urandom % 4, 0, 0, 1'b0);
		run_frame(frame_len(num_a) + 200);
		end_test(4, "trigger outside exposure");

		apb_xfer(1'b1, `REVEAL_REG_NUM_PAT, 0, 0, 0, 1'b0);
		run_frame(frame_len(0) + 200);
		end_test(5, "empty frame");

		// abort in mid-frame and run a clean frame from pattern 0
		apb_xfer(1'b1, `REVEAL_REG_NUM_PAT, num_a, 0, 0, 1'b0);
		apb_xfer(1'b1, `REVEAL_REG_PROJ_DELAY, delay_a, 0, 0, 1'b0);
		@(negedge CLK_HS);
		expose_req = 1'b1;
		n = 0;
		while (str_cnt < 2 && n < frame_len(num_a)) begin
			@(negedge CLK_HS);
			n++;
		end
		assert (str_cnt >= 2) else report_error("frame never reached its second subframe");
		apb_xfer(1'b1, `REVEAL_REG_CTRL, 1, 0, 0, 1'b0);
		apb_xfer(1'b0, `REVEAL_REG_STATUS, 0, status_idle, 32'h1c0, 1'b0);
		@(negedge CLK_HS);
		expose_req = 1'b0;
		apb_xfer(1'b1, `REVEAL_REG_CTRL, 0, 0, 0, 1'b0);
		run_frame(frame_len(num_a) + 200);
		end_test(6, "soft reset abort");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== source/reveal_top.sv ====
`include "reveal_defs.svh"

module reveal_top import reveal_pkg::*; (
	input  logic         CLK_HS,
	input  logic         arst_n,
	input  apb_req_t     apb_req,
	output apb_rsp_t     apb_rsp,
	input  logic         expose_req,
	output logic         expose_ack,
	output imager_ctrl_t imager,
	output logic         trigger_proj
);

	seq_cfg_t                  cfg;
	logic                      soft_rst;
	pat_wr_t                   pat_wr;
	exp_status_t               status;
	logic [`REVEAL_PAT_AW-1:0] rd_addr;
	pattern_t                  rd_data;
	logic                      load_start;
	logic                      fifo_flush;
	logic                      fifo_push;
	pattern_t                  fifo_din;
	logic                      fifo_pop;
	pattern_t                  fifo_head;
	logic                      fifo_empty;
	logic [3:0]                fifo_count;

	host_regs regs_i (.CLK_HS, .arst_n, .apb_req, .apb_rsp, .cfg, .soft_rst, .pat_wr, .status);

	pattern_store store_i (.CLK_HS, .pat_wr, .rd_addr, .rd_data);

	pattern_loader loader_i (.CLK_HS, .arst_n, .soft_rst, .load_start, .num_pat(cfg.num_pat),
		.rd_addr, .rd_data, .fifo_flush, .fifo_push, .fifo_din, .fifo_count);

	pattern_fifo fifo_i (.CLK_HS, .arst_n, .flush(fifo_flush), .push(fifo_push), .din(fifo_din),
		.pop(fifo_pop), .head(fifo_head), .empty(fifo_empty), .count(fifo_count));

	exposure_fsm fsm_i (.CLK_HS, .arst_n, .soft_rst, .cfg, .expose_req, .expose_ack, .load_start,
		.fifo_head, .fifo_empty, .fifo_pop, .imager, .trigger_proj, .status);

endmodule

// ==== source/exposure_fsm.sv ====
`include "reveal_defs.svh"

module exposure_fsm import reveal_pkg::*; (
	input  logic         CLK_HS,
	input  logic         arst_n,
	input  logic         soft_rst,
	input  seq_cfg_t     cfg,
	input  logic         expose_req,
	output logic         expose_ack,
	output logic         load_start,
	input  pattern_t     fifo_head,
	input  logic         fifo_empty,
	output logic         fifo_pop,
	output imager_ctrl_t imager,
	output logic         trigger_proj,
	output exp_status_t  status
);

	exp_state_e                 state;
	exp_state_e                 state_nx;
	logic [`REVEAL_EXP_W-1:0]   exp_cnt;    // pixel reset and exposure timer
	logic [5:0]                 sub_cnt;    // subframe index
	logic [`REVEAL_FRAME_W-1:0] frame_cnt;  // cycles since the frame started
	logic                       run;
	logic                       res_last;
	logic                       exp_last;
	logic                       sub_last;
	logic                       frame_met;
	logic                       trig_hit;

	assign run       = !soft_rst;
	assign res_last  = exp_cnt == `REVEAL_EXP_W'(`REVEAL_RESET_CYCLES - 1);
	assign exp_last  = ({1'b0, exp_cnt} + 1'b1) >= {1'b0, cfg.exp_time};  // zero acts as one
	assign sub_last  = (sub_cnt + 1'b1) >= cfg.num_pat;
	assign frame_met = frame_cnt >= cfg.min_frame;
	// trigger only lands inside the subframe when the delay fits
	assign trig_hit  = cfg.proj_delay < cfg.exp_time && exp_cnt == cfg.proj_delay;

	////////////////////////////////////////////////////////////////////////////
	// frame sequencer
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_nx = state;
		case (state)
			IDLE:    if (expose_req) state_nx = PIXRES;
			PIXRES:  if (res_last) state_nx = (cfg.num_pat == '0) ? DRAIN : UPLOAD;
			UPLOAD:  if (!fifo_empty) state_nx = EXPOSE;   // waits on the loader here
			EXPOSE:  if (exp_last) state_nx = sub_last ? DRAIN : UPLOAD;
			DRAIN:   if (frame_met) state_nx = DONE;
			DONE:    if (!expose_req) state_nx = IDLE;     // four-phase release
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else if (soft_rst) begin
			state <= IDLE;   // abort the frame
		end else begin
			state <= state_nx;
		end
	end

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			exp_cnt   <= '0;
			sub_cnt   <= '0;
			frame_cnt <= '0;
		end else begin
			exp_cnt <= (state_nx != state) ? '0 : exp_cnt + 1'b1;   // restart on every entry
			if (state == IDLE) begin
				sub_cnt   <= '0;
				frame_cnt <= `REVEAL_FRAME_W'(1);   // first pixres cycle counts as one
			end else begin
				if (state == EXPOSE && exp_last) sub_cnt <= sub_cnt + 1'b1;
				if (frame_cnt != '1) frame_cnt <= frame_cnt + 1'b1;   // saturate
			end
		end
	end

	// imager and handshake outputs go idle while soft reset is set
	assign imager.pix_res_glob = run && state == PIXRES;
	assign imager.stream       = run && state == UPLOAD && !fifo_empty;
	assign imager.drain_b      = !(run && state == DRAIN);
	assign imager.mask         = fifo_head;
	assign fifo_pop            = imager.stream;   // mask leaves with its stream pulse
	assign trigger_proj        = run && state == EXPOSE && trig_hit;
	assign expose_ack          = run && state == DONE;
	assign load_start          = run && state == IDLE && expose_req;

	assign status.state    = state;
	assign status.subframe = sub_cnt;

	// trigger sits in an exposure that a stream pulse opened
	a_trig_in_expose: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		$rose(trigger_proj) |-> state == EXPOSE
			&& ($past(state) == EXPOSE || $past(imager.stream)));

endmodule

// ==== source/pattern_loader.sv ====
`include "reveal_defs.svh"

module pattern_loader import reveal_pkg::*; (
	input  logic                      CLK_HS,
	input  logic                      arst_n,
	input  logic                      soft_rst,
	input  logic                      load_start,
	input  logic [5:0]                num_pat,
	output logic [`REVEAL_PAT_AW-1:0] rd_addr,
	input  pattern_t                  rd_data,
	output logic                      fifo_flush,
	output logic                      fifo_push,
	output pattern_t                  fifo_din,
	input  logic [3:0]                fifo_count
);

	logic       active;     // a frame load is running
	logic       rd_vld;     // read issued last cycle, data on rd_data now
	logic [5:0] idx;        // next store index to read
	logic [4:0] room_need;  // fifo words plus reads in flight plus a new one
	logic       issue;

	assign fifo_flush = load_start || soft_rst;

	// the word coming back this cycle is not in fifo_count yet
	assign room_need = 5'(fifo_count) + 5'(rd_vld) + 5'd1;

	assign issue = active && !fifo_flush && idx < num_pat
		&& room_need <= 5'(`REVEAL_FIFO_DEPTH);

	assign rd_addr   = idx[`REVEAL_PAT_AW-1:0];
	assign fifo_push = rd_vld && !fifo_flush;   // stale returns die with the flush
	assign fifo_din  = rd_data;

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			rd_vld <= 1'b0;
			idx    <= '0;
		end else if (fifo_flush) begin
			active <= load_start && !soft_rst;   // restart from pattern 0
			rd_vld <= 1'b0;
			idx    <= '0;
		end else begin
			rd_vld <= issue;
			if (issue) begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// ==== source/pattern_fifo.sv ====
`include "reveal_defs.svh"

module pattern_fifo import reveal_pkg::*; (
	input  logic       CLK_HS,
	input  logic       arst_n,
	input  logic       flush,
	input  logic       push,
	input  pattern_t   din,
	input  logic       pop,
	output pattern_t   head,
	output logic       empty,
	output logic [3:0] count
);

	localparam int PW = $clog2(`REVEAL_FIFO_DEPTH);

	pattern_t      mem [`REVEAL_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign full    = count == 4'(`REVEAL_FIFO_DEPTH);
	assign empty   = count == '0;
	assign head    = mem[rd_ptr];               // show-ahead, head is the next mask
	assign do_push = push && !full && !flush;   // flush wins over both strobes
	assign do_pop  = pop && !empty && !flush;

	always_ff @(posedge CLK_HS) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;   // drop everything left from the last frame
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			count <= count + 4'(do_push) - 4'(do_pop);
		end
	end

	a_no_push_full: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		push |-> !full);
	a_no_pop_empty: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		pop |-> !empty);

endmodule

// ==== source/pattern_store.sv ====
`include "reveal_defs.svh"

module pattern_store import reveal_pkg::*; (
	input  logic                      CLK_HS,
	input  pat_wr_t                   pat_wr,
	input  logic [`REVEAL_PAT_AW-1:0] rd_addr,
	output pattern_t                  rd_data
);

	pattern_t mem [`REVEAL_MAX_PAT];   // one word per subframe mask

	// host write port
	always_ff @(posedge CLK_HS) begin
		if (pat_wr.en) begin
			mem[pat_wr.addr] <= pat_wr.data;
		end
	end

	// loader read port, data one cycle behind the address
	always_ff @(posedge CLK_HS) begin
		rd_data <= mem[rd_addr];
	end

	a_wr_in_range: assert property (@(posedge CLK_HS)
		pat_wr.en |-> !$isunknown(pat_wr.addr) && int'(pat_wr.addr) < `REVEAL_MAX_PAT);

endmodule

// ==== source/host_regs.sv ====
`include "reveal_defs.svh"

module host_regs import reveal_pkg::*; (
	input  logic        CLK_HS,
	input  logic        arst_n,
	input  apb_req_t    apb_req,
	output apb_rsp_t    apb_rsp,
	output seq_cfg_t    cfg,
	output logic        soft_rst,
	output pat_wr_t     pat_wr,
	input  exp_status_t status
);

	logic                      access;    // apb access phase
	logic                      addr_hit;  // address maps to a register
	logic                      err;
	logic                      wr_ok;     // write that actually lands
	logic [`REVEAL_APB_DW-1:0] rdata;
	logic [`REVEAL_PAT_AW-1:0] pat_addr;  // store write pointer

	assign access = apb_req.psel && apb_req.penable;

	////////////////////////////////////////////////////////////////////////////
	// read mux and address decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		addr_hit = 1'b1;
		rdata    = '0;
		case (apb_req.paddr)
			`REVEAL_REG_CTRL:       rdata[0] = soft_rst;
			`REVEAL_REG_EXP:        rdata[`REVEAL_EXP_W-1:0] = cfg.exp_time;
			`REVEAL_REG_NUM_PAT:    rdata[5:0] = cfg.num_pat;
			`REVEAL_REG_MIN_FRAME:  rdata[`REVEAL_FRAME_W-1:0] = cfg.min_frame;
			`REVEAL_REG_PROJ_DELAY: rdata[`REVEAL_DELAY_W-1:0] = cfg.proj_delay;
			`REVEAL_REG_PAT_ADDR:   rdata[`REVEAL_PAT_AW-1:0] = pat_addr;
			`REVEAL_REG_PAT_DATA:   rdata = '0;                  // write only port
			`REVEAL_REG_STATUS:     rdata[$bits(exp_status_t)-1:0] = status;
			default:                addr_hit = 1'b0;
		endcase
	end

	// slave error: bad address, write to status, pattern count out of range
	assign err = access && (!addr_hit
		|| (apb_req.pwrite && apb_req.paddr == `REVEAL_REG_STATUS)
		|| (apb_req.pwrite && apb_req.paddr == `REVEAL_REG_NUM_PAT
			&& apb_req.pwdata > `REVEAL_MAX_PAT));

	assign wr_ok = access && apb_req.pwrite && !err;

	assign apb_rsp.prdata  = rdata;
	assign apb_rsp.pready  = 1'b1;   // never stretch the access phase
	assign apb_rsp.pslverr = err;

	// pattern data goes straight to the store at the current pointer
	assign pat_wr.en   = wr_ok && apb_req.paddr == `REVEAL_REG_PAT_DATA;
	assign pat_wr.addr = pat_addr;
	assign pat_wr.data = apb_req.pwdata[`REVEAL_PAT_W-1:0];

	always_ff @(posedge CLK_HS or negedge arst_n) begin
		if (!arst_n) begin
			soft_rst       <= 1'b1;   // hold the sequencer until the host is ready
			cfg.exp_time   <= `REVEAL_EXP_W'(1);
			cfg.num_pat    <= 6'd1;
			cfg.min_frame  <= `REVEAL_FRAME_W'(1);
			cfg.proj_delay <= `REVEAL_DELAY_W'(1);
			pat_addr       <= '0;
		end else if (wr_ok) begin
			case (apb_req.paddr)
				`REVEAL_REG_CTRL:       soft_rst <= apb_req.pwdata[0];
				`REVEAL_REG_EXP:        cfg.exp_time <= apb_req.pwdata[`REVEAL_EXP_W-1:0];
				`REVEAL_REG_NUM_PAT:    cfg.num_pat <= apb_req.pwdata[5:0];
				`REVEAL_REG_MIN_FRAME:  cfg.min_frame <= apb_req.pwdata[`REVEAL_FRAME_W-1:0];
				`REVEAL_REG_PROJ_DELAY: cfg.proj_delay <= apb_req.pwdata[`REVEAL_DELAY_W-1:0];
				`REVEAL_REG_PAT_ADDR:   pat_addr <= apb_req.pwdata[`REVEAL_PAT_AW-1:0];
				`REVEAL_REG_PAT_DATA:   pat_addr <= pat_addr + 1'b1;  // wraps at store depth
				default: ;
			endcase
		end
	end

	// host side protocol
	a_penable_in_sel: assert property (@(posedge CLK_HS) disable iff (!arst_n)
		apb_req.penable |-> apb_req.psel);

endmodule

// ==== source/reveal_pkg.sv ====
`include "reveal_defs.svh"

package reveal_pkg;

	typedef logic [`REVEAL_PAT_W-1:0] pattern_t;

	typedef struct packed {
		logic [`REVEAL_EXP_W-1:0]   exp_time;   // cycles per subframe
		logic [5:0]                 num_pat;    // subframes per frame, 0..32
		logic [`REVEAL_FRAME_W-1:0] min_frame;
		logic [`REVEAL_DELAY_W-1:0] proj_delay;
	} seq_cfg_t;

	typedef struct packed {
		logic                     en;
		logic [`REVEAL_PAT_AW-1:0] addr;
		pattern_t                 data;
	} pat_wr_t;

	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`REVEAL_APB_AW-1:0] paddr;
		logic [`REVEAL_APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`REVEAL_APB_DW-1:0] prdata;
		logic                     pready;
		logic                     pslverr;
	} apb_rsp_t;

	// imager side, drain_b is active low
	typedef struct packed {
		logic     pix_res_glob;
		logic     stream;
		logic     drain_b;
		pattern_t mask;
	} imager_ctrl_t;

	typedef enum logic [2:0] {IDLE, PIXRES, UPLOAD, EXPOSE, DRAIN, DONE} exp_state_e;

	typedef struct packed {
		exp_state_e state;
		logic [5:0] subframe;
	} exp_status_t;

endpackage

// ==== include/reveal_defs.svh ====
`ifndef REVEAL_DEFS_SVH
`define REVEAL_DEFS_SVH

// pattern path
`define REVEAL_PAT_W          18   // one mask word, one bit per imager column group
`define REVEAL_MAX_PAT        32   // store depth
`define REVEAL_PAT_AW         5
`define REVEAL_FIFO_DEPTH     8

// sequencer counters
`define REVEAL_EXP_W          16   // exposure per subframe, in CLK_HS cycles
`define REVEAL_FRAME_W        20   // minimum frame time
`define REVEAL_DELAY_W        16   // projector trigger delay
`define REVEAL_RESET_CYCLES   4    // global pixel reset length

// apb bus
`define REVEAL_APB_AW         8
`define REVEAL_APB_DW         32

// register map
`define REVEAL_REG_CTRL       8'h00   // bit 0 soft reset, comes up set
`define REVEAL_REG_EXP        8'h04
`define REVEAL_REG_NUM_PAT    8'h08
`define REVEAL_REG_MIN_FRAME  8'h0C
`define REVEAL_REG_PROJ_DELAY 8'h10
`define REVEAL_REG_PAT_ADDR   8'h14
`define REVEAL_REG_PAT_DATA   8'h18   // write only
`define REVEAL_REG_STATUS     8'h1C   // read only

`endif
